//--- files.f
+incdir+include
logic/dlx_pkg.sv
logic/rf_port_if.sv
logic/barrel_shifter.sv
logic/alu_32.sv
logic/operand_select.sv
logic/reg_file.sv
logic/exec_control.sv
logic/dlx_exec_top.sv
verification/dlx_exec_tb.sv

//--- verification/dlx_exec_tb.sv
module dlx_exec_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic reset;
	logic instr_req;
	logic [31:0] instr;
	logic instr_ack;
	logic [31:0] result;
	logic illegal;

	logic [31:0] model_regs [32];
	logic [31:0] exp_result;
	logic exp_illegal;
	int seed = 32'h6f40f99b;

	dlx_exec_top dut_i (
		.clk(clk),
		.reset(reset),
		.instr_req(instr_req),
		.instr(instr),
		.instr_ack(instr_ack),
		.result(result),
		.illegal(illegal)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// Expected ALU value from the DLX rules
	function automatic logic [31:0] alu_ref(input logic [5:0] func, input logic [31:0] a,
		input logic [31:0] b);
		case (func)
			dlx_pkg::ALU_SLL: return a << b[4:0];
			dlx_pkg::ALU_SRL: return a >> b[4:0];
			dlx_pkg::ALU_SRA: return $signed(a) >>> b[4:0];
			dlx_pkg::ALU_ADD: return a + b;
			dlx_pkg::ALU_SUB: return a - b;
			dlx_pkg::ALU_AND: return a & b;
			dlx_pkg::ALU_OR: return a | b;
			dlx_pkg::ALU_XOR: return a ^ b;
			dlx_pkg::ALU_SEQ: return {31'd0, a == b};
			dlx_pkg::ALU_SNE: return {31'd0, a != b};
			dlx_pkg::ALU_SLT: return {31'd0, $signed(a) < $signed(b)};
			dlx_pkg::ALU_SGT: return {31'd0, $signed(a) > $signed(b)};
			dlx_pkg::ALU_SLE: return {31'd0, $signed(a) <= $signed(b)};
			dlx_pkg::ALU_SGE: return {31'd0, $signed(a) >= $signed(b)};
			default: return '0;
		endcase
	endfunction

	// Four-phase transaction with req kept high for hold cycles after ack
	task automatic run_instr(input logic [31:0] word, input logic [31:0] exp_val,
		input logic exp_bad, input int hold);
		int cycles;
		@(negedge clk);
		exp_result = exp_val;
		exp_illegal = exp_bad;
		instr = word;
		instr_req = 1'b1;
		cycles = 0;
		while (!instr_ack) begin
			if (cycles == 20)
				abort_run("instr_ack never rose within 20 cycles of instr_req");
			else begin
				@(negedge clk);
				cycles++;
			end
		end
		repeat (hold) @(negedge clk);
		instr_req = 1'b0;
		cycles = 0;
		while (instr_ack) begin
			if (cycles == 20)
				abort_run("instr_ack never fell within 20 cycles after instr_req dropped");
			else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic exec_r(input logic [5:0] func, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [31:0] val;
		val = alu_ref(func, model_regs[rs1], model_regs[rs2]);
		run_instr({6'h00, rs1, rs2, rd, 5'd0, func}, val, 1'b0, 0);
		if (rd != 5'd0)
			model_regs[rd] = val; // r0 stays zero
	endtask

	task automatic exec_i(input logic [5:0] op, input logic [5:0] func, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [15:0] imm);
		logic [31:0] b;
		logic [31:0] val;
		if (op inside {dlx_pkg::ANDI, dlx_pkg::ORI, dlx_pkg::XORI})
			b = {16'd0, imm};
		else
			b = {{16{imm[15]}}, imm};
		val = alu_ref(func, model_regs[rs1], b);
		run_instr({op, rs1, rd, imm}, val, 1'b0, 0);
		if (rd != 5'd0)
			model_regs[rd] = val;
	endtask

	assert property (@(posedge clk) $fell(reset) |-> !instr_ack && !illegal && result == '0)
		else abort_run($sformatf("Fail at %0t: outputs not cleared by reset", $time));

	assert property (@(posedge clk) disable iff (reset) $rose(instr_req) |=> !instr_ack ##1 instr_ack)
		else abort_run($sformatf("Fail at %0t: instr_ack not raised one edge after capture", $time));

	assert property (@(posedge clk) disable iff (reset) instr_ack && !instr_req |=> !instr_ack)
		else abort_run($sformatf("Fail at %0t: instr_ack did not fall after req low", $time));

	assert property (@(posedge clk) disable iff (reset) instr_ack && instr_req |=> instr_ack)
		else abort_run($sformatf("Fail at %0t: instr_ack dropped while req held", $time));

	assert property (@(posedge clk) disable iff (reset)
		instr_ack && $past(instr_ack) |-> $stable(result) && $stable(illegal))
		else abort_run($sformatf("Fail at %0t: result or illegal changed during ack", $time));

	// Result only matters for legal instructions
	assert property (@(posedge clk) disable iff (reset)
		$rose(instr_ack) |-> illegal == exp_illegal && (exp_illegal || result == exp_result))
		else abort_run($sformatf("Fail at %0t: result %h illegal %b, expected %h illegal %b",
			$time, $sampled(result), $sampled(illegal), exp_result, exp_illegal));

	initial begin
		logic [5:0] set_funcs [6];
		logic [5:0] set_ops [6];
		logic [4:0] src_a [4];
		logic [4:0] src_b [4];
		set_funcs = '{dlx_pkg::ALU_SEQ, dlx_pkg::ALU_SNE, dlx_pkg::ALU_SLT,
			dlx_pkg::ALU_SGT, dlx_pkg::ALU_SLE, dlx_pkg::ALU_SGE};
		set_ops = '{dlx_pkg::SEQI, dlx_pkg::SNEI, dlx_pkg::SLTI,
			dlx_pkg::SGTI, dlx_pkg::SLEI, dlx_pkg::SGEI};
		src_a = '{5'd1, 5'd1, 5'd7, 5'd9}; // Equal, random, two overflowing pairs
		src_b = '{5'd1, 5'd2, 5'd8, 5'd7};
		reset = 1'b1;
		instr_req = 1'b0;
		instr = '0;
		exp_result = '0;
		exp_illegal = 1'b0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		exec_r(dlx_pkg::ALU_OR, 5'd20, 5'd21, 5'd31); // Untouched registers read zero

		// Random 32-bit loads built from ADDI, SLLI and ORI
		for (int r = 1; r <= 6; r++) begin
			exec_i(dlx_pkg::ADDI, dlx_pkg::ALU_ADD, 5'(r), 5'd0, 16'($random(seed)));
			exec_i(dlx_pkg::SLLI, dlx_pkg::ALU_SLL, 5'(r), 5'(r), 16'd16);
			exec_i(dlx_pkg::ORI, dlx_pkg::ALU_OR, 5'(r), 5'(r), 16'($random(seed)));
		end
		exec_i(dlx_pkg::ADDI, dlx_pkg::ALU_ADD, 5'd7, 5'd0, 16'd1);
		exec_i(dlx_pkg::SLLI, dlx_pkg::ALU_SLL, 5'd7, 5'd7, 16'd31); // Most negative
		exec_i(dlx_pkg::ADDI, dlx_pkg::ALU_ADD, 5'd8, 5'd0, 16'd1);
		exec_i(dlx_pkg::ADDI, dlx_pkg::ALU_ADD, 5'd9, 5'd0, 16'hffff);
		exec_i(dlx_pkg::SRLI, dlx_pkg::ALU_SRL, 5'd9, 5'd9, 16'd1); // Most positive

		exec_r(dlx_pkg::ALU_ADD, 5'd10, 5'd1, 5'd2);
		exec_r(dlx_pkg::ALU_SUB, 5'd11, 5'd3, 5'd4);
		exec_i(dlx_pkg::SUBI, dlx_pkg::ALU_SUB, 5'd12, 5'd5, 16'($random(seed)));
		exec_r(dlx_pkg::ALU_ADD, 5'd0, 5'd1, 5'd2);
		exec_r(dlx_pkg::ALU_ADD, 5'd13, 5'd0, 5'd1);

		// Back-pressure with req held three extra cycles
		run_instr({6'h00, 5'd3, 5'd4, 5'd0, 5'd0, 6'h20}, model_regs[3] + model_regs[4], 1'b0, 3);

		exec_r(dlx_pkg::ALU_AND, 5'd14, 5'd1, 5'd2);
		exec_r(dlx_pkg::ALU_OR, 5'd14, 5'd3, 5'd4);
		exec_r(dlx_pkg::ALU_XOR, 5'd14, 5'd5, 5'd6);
		exec_i(dlx_pkg::ANDI, dlx_pkg::ALU_AND, 5'd14, 5'd1, 16'h8f0f);
		exec_i(dlx_pkg::ORI, dlx_pkg::ALU_OR, 5'd14, 5'd2, 16'hc3a5);
		exec_i(dlx_pkg::XORI, dlx_pkg::ALU_XOR, 5'd14, 5'd7, 16'hf00f);
		exec_i(dlx_pkg::ADDI, dlx_pkg::ALU_ADD, 5'd14, 5'd1, 16'h9abc);

		exec_r(dlx_pkg::ALU_SLL, 5'd18, 5'd1, 5'd6);
		exec_r(dlx_pkg::ALU_SRL, 5'd18, 5'd2, 5'd6);
		exec_r(dlx_pkg::ALU_SRA, 5'd18, 5'd7, 5'd6); // Fills with ones
		exec_r(dlx_pkg::ALU_SRA, 5'd18, 5'd3, 5'd5);
		exec_i(dlx_pkg::SLLI, dlx_pkg::ALU_SLL, 5'd19, 5'd2, 16'h0025);
		exec_i(dlx_pkg::SRLI, dlx_pkg::ALU_SRL, 5'd19, 5'd1, 16'hffe3);
		exec_i(dlx_pkg::SRAI, dlx_pkg::ALU_SRA, 5'd19, 5'd7, 16'h0ff4);

		foreach (set_funcs[f]) begin
			for (int p = 0; p < 4; p++)
				exec_r(set_funcs[f], 5'd16, src_a[p], src_b[p]);
			exec_i(set_ops[f], set_funcs[f], 5'd17, 5'd9, 16'hffff);
			exec_i(set_ops[f], set_funcs[f], 5'd17, 5'd7, 16'h7fff);
		end

		// Unknown opcode then unknown func leave their destinations unchanged
		run_instr({6'h3f, 5'd0, 5'd1, 16'h1234}, '0, 1'b1, 0);
		exec_r(dlx_pkg::ALU_ADD, 5'd15, 5'd1, 5'd0);
		run_instr({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f}, '0, 1'b1, 0);
		exec_r(dlx_pkg::ALU_ADD, 5'd15, 5'd3, 5'd0);

		repeat (4) @(negedge clk);
		$display(">>> PASS");
		$finish;
	end
endmodule

//--- logic/dlx_exec_top.sv
`include "dlx_config.svh"

module dlx_exec_top (
	input logic clk,
	input logic reset,
	input logic instr_req,
	input logic [31:0] instr,
	output logic instr_ack,
	output logic [`DLX_XLEN-1:0] result,
	output logic illegal
);

	dlx_pkg::dlx_instr_u captured;
	dlx_pkg::alu_func_e alu_func;
	logic [`DLX_XLEN-1:0] operand_b;
	logic [`DLX_XLEN-1:0] alu_result;
	logic op_illegal;

	rf_port_if rf ();

	exec_control control_i (
		.clk(clk),
		.reset(reset),
		.instr_req(instr_req),
		.instr(instr),
		.instr_ack(instr_ack),
		.result(result),
		.illegal(illegal),
		.captured(captured),
		.alu_result(alu_result),
		.op_illegal(op_illegal),
		.rf(rf.user)
	);

	reg_file regs_i (
		.clk(clk),
		.reset(reset),
		.rf(rf.bank)
	);

	operand_select select_i (
		.captured(captured),
		.rs2_data(rf.rd_data_b),
		.alu_func(alu_func),
		.operand_b(operand_b),
		.op_illegal(op_illegal)
	);

	// A comes straight off read port a
	alu_32 alu_i (
		.a(rf.rd_data_a),
		.b(operand_b),
		.func(alu_func),
		.out(alu_result)
	);
endmodule

//--- logic/exec_control.sv
`include "dlx_config.svh"

module exec_control (
	input logic clk,
	input logic reset,
	input logic instr_req,
	input dlx_pkg::dlx_instr_u instr,
	output logic instr_ack,
	output logic [`DLX_XLEN-1:0] result,
	output logic illegal,
	output dlx_pkg::dlx_instr_u captured,
	input logic [`DLX_XLEN-1:0] alu_result,
	input logic op_illegal,
	rf_port_if.user rf
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_EXECUTE = 2'd1;
	localparam logic [1:0] ST_ACK = 2'd2;

	logic [1:0] state;
	logic is_r_type;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			result <= '0;
			illegal <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (instr_req)
						state <= ST_EXECUTE;
				end
				ST_EXECUTE: begin
					// Operands settled during this cycle
					state <= ST_ACK;
					result <= alu_result;
					illegal <= op_illegal;
				end
				ST_ACK: begin
					if (!instr_req) // Four-phase return to zero
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Instruction word only loads on an accepted request
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && instr_req)
			captured <= instr;
	end

	assign instr_ack = (state == ST_ACK);

	assign is_r_type = (captured.r_view.opcode == dlx_pkg::R_TYPE);

	// Source fields sit in the same place in both views
	assign rf.rd_addr_a = captured.r_view.rs1;
	assign rf.rd_addr_b = captured.r_view.rs2;
	assign rf.wr_addr = is_r_type ? captured.r_view.rd : captured.i_view.rd;
	assign rf.wr_data = alu_result;
	assign rf.wr_en = (state == ST_EXECUTE) && !op_illegal; // One-cycle pulse
endmodule

//--- logic/reg_file.sv
`include "dlx_config.svh"

module reg_file (
	input logic clk,
	input logic reset,
	rf_port_if.bank rf
);

	logic [`DLX_XLEN-1:0] regs [`DLX_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DLX_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (rf.wr_en && rf.wr_addr != '0) begin
			regs[rf.wr_addr] <= rf.wr_data; // r0 keeps its reset zero
		end
	end

	// Combinational reads
	assign rf.rd_data_a = regs[rf.rd_addr_a];
	assign rf.rd_data_b = regs[rf.rd_addr_b];
endmodule

//--- logic/operand_select.sv
`include "dlx_config.svh"

module operand_select (
	input dlx_pkg::dlx_instr_u captured,
	input logic [`DLX_XLEN-1:0] rs2_data,
	output dlx_pkg::alu_func_e alu_func,
	output logic [`DLX_XLEN-1:0] operand_b,
	output logic op_illegal
);

	logic [`DLX_XLEN-1:0] imm_zext;
	logic [`DLX_XLEN-1:0] imm_sext;

	assign imm_zext = {{(`DLX_XLEN-16){1'b0}}, captured.i_view.imm16};
	assign imm_sext = {{(`DLX_XLEN-16){captured.i_view.imm16[15]}}, captured.i_view.imm16};

	always_comb begin
		alu_func = dlx_pkg::ALU_ADD;
		operand_b = imm_sext; // Most I-types sign extend
		op_illegal = 1'b0;
		case (captured.i_view.opcode)
			dlx_pkg::R_TYPE: begin
				operand_b = rs2_data;
				case (captured.r_view.func)
					dlx_pkg::ALU_SLL, dlx_pkg::ALU_SRL, dlx_pkg::ALU_SRA,
					dlx_pkg::ALU_ADD, dlx_pkg::ALU_SUB,
					dlx_pkg::ALU_AND, dlx_pkg::ALU_OR, dlx_pkg::ALU_XOR,
					dlx_pkg::ALU_SEQ, dlx_pkg::ALU_SNE, dlx_pkg::ALU_SLT,
					dlx_pkg::ALU_SGT, dlx_pkg::ALU_SLE, dlx_pkg::ALU_SGE:
						alu_func = dlx_pkg::alu_func_e'(captured.r_view.func);
					default: op_illegal = 1'b1;
				endcase
			end
			dlx_pkg::ADDI: alu_func = dlx_pkg::ALU_ADD;
			dlx_pkg::SUBI: alu_func = dlx_pkg::ALU_SUB;
			// Logic immediates take the raw 16 bits
			dlx_pkg::ANDI: begin
				alu_func = dlx_pkg::ALU_AND;
				operand_b = imm_zext;
			end
			dlx_pkg::ORI: begin
				alu_func = dlx_pkg::ALU_OR;
				operand_b = imm_zext;
			end
			dlx_pkg::XORI: begin
				alu_func = dlx_pkg::ALU_XOR;
				operand_b = imm_zext;
			end
			dlx_pkg::SLLI: alu_func = dlx_pkg::ALU_SLL; // Only low five bits reach shifter
			dlx_pkg::SRLI: alu_func = dlx_pkg::ALU_SRL;
			dlx_pkg::SRAI: alu_func = dlx_pkg::ALU_SRA;
			dlx_pkg::SEQI: alu_func = dlx_pkg::ALU_SEQ;
			dlx_pkg::SNEI: alu_func = dlx_pkg::ALU_SNE;
			dlx_pkg::SLTI: alu_func = dlx_pkg::ALU_SLT;
			dlx_pkg::SGTI: alu_func = dlx_pkg::ALU_SGT;
			dlx_pkg::SLEI: alu_func = dlx_pkg::ALU_SLE;
			dlx_pkg::SGEI: alu_func = dlx_pkg::ALU_SGE;
			default: op_illegal = 1'b1;
		endcase
	end
endmodule

//--- logic/alu_32.sv
`include "dlx_config.svh"

module alu_32 (
	input logic [`DLX_XLEN-1:0] a,
	input logic [`DLX_XLEN-1:0] b,
	input dlx_pkg::alu_func_e func,
	output logic [`DLX_XLEN-1:0] out
);

	localparam int XLEN = `DLX_XLEN;

	logic is_add;
	logic c_in;
	logic [XLEN-1:0] b_adder;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] shift_out;
	logic overflow;
	logic zero;
	logic less;

	// Everything except ADD runs through the subtractor
	assign is_add = (func == dlx_pkg::ALU_ADD);
	assign b_adder = is_add ? b : ~b;
	assign c_in = ~is_add;
	assign sum = a + b_adder + {{(XLEN-1){1'b0}}, c_in};

	// Two's complement overflow of a - b
	assign overflow = (a[XLEN-1] == b_adder[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
	assign zero = (sum == '0);
	assign less = sum[XLEN-1] ^ overflow; // Signed a < b

	barrel_shifter shifter_i (
		.value(a),
		.amount(b[4:0]),
		.kind(func[1:0]),
		.shifted(shift_out)
	);

	always_comb begin
		case (func)
			dlx_pkg::ALU_SLL,
			dlx_pkg::ALU_SRL,
			dlx_pkg::ALU_SRA: out = shift_out;
			dlx_pkg::ALU_ADD,
			dlx_pkg::ALU_SUB: out = sum;
			dlx_pkg::ALU_AND: out = a & b;
			dlx_pkg::ALU_OR: out = a | b;
			dlx_pkg::ALU_XOR: out = a ^ b;
			dlx_pkg::ALU_SEQ: out = XLEN'(zero);
			dlx_pkg::ALU_SNE: out = XLEN'(!zero);
			dlx_pkg::ALU_SLT: out = XLEN'(less);
			dlx_pkg::ALU_SGT: out = XLEN'(!less && !zero);
			dlx_pkg::ALU_SLE: out = XLEN'(less || zero);
			dlx_pkg::ALU_SGE: out = XLEN'(!less);
			default: out = sum;
		endcase
	end
endmodule

//--- logic/barrel_shifter.sv
`include "dlx_config.svh"

module barrel_shifter (
	input logic [`DLX_XLEN-1:0] value,
	input logic [4:0] amount,
	input logic [1:0] kind, // 00 left, 10 logical right, 11 arithmetic right
	output logic [`DLX_XLEN-1:0] shifted
);

	localparam int XLEN = `DLX_XLEN;

	logic fill;
	logic [XLEN-1:0] stage [6];

	assign fill = kind[0] & value[XLEN-1];
	assign stage[0] = value;

	// Stage i moves by 2**i
	for (genvar i = 0; i < 5; i++) begin : g_stage
		localparam int STEP = 1 << i;
		logic [XLEN-1:0] moved;

		assign moved = kind[1] ? {{STEP{fill}}, stage[i][XLEN-1:STEP]}
			: {stage[i][XLEN-1-STEP:0], {STEP{1'b0}}};
		assign stage[i+1] = amount[i] ? moved : stage[i];
	end

	assign shifted = stage[5];
endmodule

//--- logic/rf_port_if.sv
`include "dlx_config.svh"

interface rf_port_if;
	localparam int ADDR_W = $clog2(`DLX_REG_COUNT);

	logic [ADDR_W-1:0] rd_addr_a;
	logic [ADDR_W-1:0] rd_addr_b;
	logic [`DLX_XLEN-1:0] rd_data_a;
	logic [`DLX_XLEN-1:0] rd_data_b;
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [`DLX_XLEN-1:0] wr_data;

	// Execute side
	modport user (output rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
		input rd_data_a, rd_data_b);

	modport bank (input rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
		output rd_data_a, rd_data_b);
endinterface

//--- logic/dlx_pkg.sv
package dlx_pkg;

	// Major opcode, bits 31:26
	typedef enum logic [5:0] {
		R_TYPE = 6'h00,
		ADDI   = 6'h08,
		SUBI   = 6'h0a,
		ANDI   = 6'h0c,
		ORI    = 6'h0d,
		XORI   = 6'h0e,
		SLLI   = 6'h14,
		SRLI   = 6'h16,
		SRAI   = 6'h17,
		SEQI   = 6'h18,
		SNEI   = 6'h19,
		SLTI   = 6'h1a,
		SGTI   = 6'h1b,
		SLEI   = 6'h1c,
		SGEI   = 6'h1d
	} dlx_opcode_e;

	// ALU function codes, same values as the R-type func field
	typedef enum logic [5:0] {
		ALU_SLL = 6'h04,
		ALU_SRL = 6'h06,
		ALU_SRA = 6'h07, // Low two bits double as shift kind
		ALU_ADD = 6'h20,
		ALU_SUB = 6'h22,
		ALU_AND = 6'h24,
		ALU_OR  = 6'h25,
		ALU_XOR = 6'h26,
		ALU_SEQ = 6'h28,
		ALU_SNE = 6'h29,
		ALU_SLT = 6'h2a,
		ALU_SGT = 6'h2b,
		ALU_SLE = 6'h2c,
		ALU_SGE = 6'h2d
	} alu_func_e;

	typedef struct packed {
		dlx_opcode_e opcode;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] func;
	} dlx_r_view_t;

	// Destination moves up to bits 20:16 here
	typedef struct packed {
		dlx_opcode_e opcode;
		logic [4:0] rs1;
		logic [4:0] rd;
		logic [15:0] imm16;
	} dlx_i_view_t;

	typedef union packed {
		dlx_r_view_t r_view;
		dlx_i_view_t i_view;
	} dlx_instr_u;

endpackage

//--- include/dlx_config.svh
`ifndef DLX_CONFIG_SVH
`define DLX_CONFIG_SVH

// Datapath and register width
`define DLX_XLEN 32

// Register file depth
`define DLX_REG_COUNT 32

`endif
